/* logic/crtc_h_timing.sv */
// Outputs decode h_count combinationally; lowering h_total below h_count ends the line at once.
`default_nettype none

module crtc_h_timing import crtc_pkg::*; (
    input  wire                        pi_read,
    input  wire                        reset,
    input  wire [h_bits-1:0]           h_total,
    input  wire [h_bits-1:0]           h_displayed,
    input  wire [h_bits-1:0]           h_sync_pos,
    input  wire [sync_width_bits-1:0] h_sync_width,
    output logic [h_bits-1:0]          h_count,
    output logic                       h_display,
    output logic                       hsync_raw,
    output logic                       line_end
);
    logic [h_bits-1:0]        sync_offset;   // Characters since the sync position, mod 256.
    logic [sync_width_bits:0] sync_span;     // One bit wider so that 16 fits.

    // Greater-or-equal catches a count that overshot after R0 was rewritten.
    assign line_end = h_count >= h_total;

    always_ff @(posedge pi_read) begin
        if (reset) begin
            h_count <= '0;
        end else if (line_end) begin
            h_count <= '0;                    // Wrap to the first character.
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign h_display = h_count < h_displayed;  // Visible part of the line.

    // A zero width field sets the top bit, which reads as 16.
    assign sync_span   = {h_sync_width == '0, h_sync_width};
    assign sync_offset = h_count - h_sync_pos;
    assign hsync_raw   = sync_offset < h_bits'(sync_span);  // Wraps past the line end if it must.
endmodule

`default_nettype wire

/* logic/crtc_pkg.sv */
// CRTC register map and PET reset timing; light pen, cursor, interlace and status registers are inert.
`default_nettype none

package crtc_pkg;
    localparam int reg_count      = 18; // R0 to R17, as on the 6545 and 6845.
    localparam int reg_index_bits = 5;  // Width of the address register.

    // Register indices that the timing logic decodes.
    localparam int r0_h_total       = 0;  // Characters per line, minus one.
    localparam int r1_h_displayed   = 1;  // Visible characters per line.
    localparam int r2_h_sync_pos    = 2;  // Character at which hsync begins.
    localparam int r3_sync_width    = 3;  // Vsync width in 7:4, hsync width in 3:0.
    localparam int r4_v_total       = 4;  // Rows per frame, minus one.
    localparam int r5_v_line_adjust = 5;  // Extra scan lines after the last row.
    localparam int r6_v_displayed   = 6;  // Visible rows per frame.
    localparam int r7_v_sync_pos    = 7;  // Row at which vsync begins.
    localparam int r9_scan_line     = 9;  // Scan lines per row, minus one.
    localparam int r12_start_high   = 12; // Start address, bits 13:8 in 5:0.
    localparam int r13_start_low    = 13; // Start address, bits 7:0.

    // Field widths after slicing.
    localparam int h_bits          = 8;
    localparam int v_bits          = 7;
    localparam int adjust_bits     = 5;
    localparam int scan_bits       = 5;
    localparam int sync_width_bits = 4;  // A width of zero stands for 16.
    localparam int addr_bits       = 14; // Video memory address.

    // Power-up values give the 15.625 kHz / 60 Hz raster of a PET without a CRTC.
    localparam logic [7:0] reset_values [reg_count] = '{
        8'd63, 8'd40, 8'd48, 8'h15, 8'd32, 8'd0, 8'd25, 8'd28, 8'd0,
        8'd7, 8'd0, 8'd0, 8'h10, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0
    };

    // The host sees R0 to R15 through this window.
    localparam logic [15:0] host_window_low  = 16'hE8F0;
    localparam logic [15:0] host_window_high = 16'hE8FF;
endpackage

`default_nettype wire

/* logic/crtc_registers.sv */
// CPU writes are levels sampled on pi_read; host read-back reaches R0 to R15 only, one cycle late.
`default_nettype none

module crtc_registers import crtc_pkg::*; (
    input  wire                        pi_read,
    input  wire                        reset,
    input  wire                        crtc_select,    // High when the CPU addresses $E8xx.
    input  wire [16:0]                 bus_addr,       // Only bit 0 matters here.
    input  wire [7:0]                  bus_data_in,
    input  wire                        cpu_write,
    input  wire [15:0]                 pi_addr,
    output logic [7:0]                 crtc_data_out,
    output logic                       crtc_data_out_enable,
    output logic [h_bits-1:0]          h_total,
    output logic [h_bits-1:0]          h_displayed,
    output logic [h_bits-1:0]          h_sync_pos,
    output logic [sync_width_bits-1:0] h_sync_width,
    output logic [v_bits-1:0]          v_total,
    output logic [adjust_bits-1:0]     v_line_adjust,
    output logic [v_bits-1:0]          v_displayed,
    output logic [v_bits-1:0]          v_sync_pos,
    output logic [sync_width_bits-1:0] v_sync_width,
    output logic [scan_bits-1:0]       char_height,
    output logic [addr_bits-1:0]       start_address
);
    logic [7:0]                regs [reg_count];   // The register file itself.
    logic [reg_index_bits-1:0] address_register;   // Selects the register an odd write lands in.
    logic                      cpu_access;
    logic                      in_window;

    assign cpu_access = crtc_select && cpu_write;  // A write needs both in the same cycle.

    // Even addresses load the index, odd addresses load the indexed register.
    always_ff @(posedge pi_read) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= reset_values[i];
            end
            address_register <= '0;
        end else if (cpu_access) begin
            if (!bus_addr[0]) begin
                address_register <= bus_data_in[reg_index_bits-1:0];
            end else if (address_register < reg_count) begin  // R18 and up do not exist.
                regs[address_register] <= bus_data_in;
            end
        end
    end

    // The window decode is combinational so the host sees the enable at once.
    assign in_window = (pi_addr >= host_window_low) && (pi_addr <= host_window_high);
    assign crtc_data_out_enable = in_window;

    // The byte follows one cycle later; outside the window the old byte holds.
    always_ff @(posedge pi_read) begin
        if (in_window) begin
            crtc_data_out <= regs[pi_addr[3:0]];
        end
    end

    // Slice the registers into the fields the timing blocks use.
    assign h_total       = regs[r0_h_total];
    assign h_displayed   = regs[r1_h_displayed];
    assign h_sync_pos    = regs[r2_h_sync_pos];
    assign h_sync_width  = regs[r3_sync_width][3:0];    // Low nibble, in characters.
    assign v_sync_width  = regs[r3_sync_width][7:4];    // High nibble, in scan lines.
    assign v_total       = regs[r4_v_total][v_bits-1:0];
    assign v_line_adjust = regs[r5_v_line_adjust][adjust_bits-1:0];
    assign v_displayed   = regs[r6_v_displayed][v_bits-1:0];
    assign v_sync_pos    = regs[r7_v_sync_pos][v_bits-1:0];
    assign char_height   = regs[r9_scan_line][scan_bits-1:0];
    // The high byte only contributes six bits to the 14-bit address.
    assign start_address = {regs[r12_start_high][5:0], regs[r13_start_low]};
endmodule

`default_nettype wire

/* logic/crtc_top.sv */
// Single clock domain on pi_read; the raster free-runs from reset and has no stall input.
`default_nettype none

module crtc_top import crtc_pkg::*; (
    input  wire                  pi_read,
    input  wire                  reset,
    input  wire                  crtc_select,
    input  wire [16:0]           bus_addr,
    input  wire [7:0]            bus_data_in,
    input  wire                  cpu_write,
    input  wire [15:0]           pi_addr,
    output logic [7:0]           crtc_data_out,
    output logic                 crtc_data_out_enable,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 display_enable,
    output logic [addr_bits-1:0] memory_address,
    output logic [scan_bits-1:0] row_address
);
    // Register fields.
    logic [h_bits-1:0]          h_total;
    logic [h_bits-1:0]          h_displayed;
    logic [h_bits-1:0]          h_sync_pos;
    logic [sync_width_bits-1:0] h_sync_width;
    logic [v_bits-1:0]          v_total;
    logic [adjust_bits-1:0]     v_line_adjust;
    logic [v_bits-1:0]          v_displayed;
    logic [v_bits-1:0]          v_sync_pos;
    logic [sync_width_bits-1:0] v_sync_width;
    logic [scan_bits-1:0]       char_height;
    logic [addr_bits-1:0]       start_address;
    // Raster state between the timing blocks and the combiner.
    logic [h_bits-1:0]          h_count;
    logic                       h_display;
    logic                       hsync_raw;
    logic                       line_end;
    logic [scan_bits-1:0]       scan_line;
    logic                       v_display;
    logic                       vsync_raw;
    logic [addr_bits-1:0]       row_start;

    crtc_registers u_registers (
        .pi_read(pi_read), .reset(reset), .crtc_select(crtc_select),
        .bus_addr(bus_addr), .bus_data_in(bus_data_in), .cpu_write(cpu_write),
        .pi_addr(pi_addr), .crtc_data_out(crtc_data_out),
        .crtc_data_out_enable(crtc_data_out_enable),
        .h_total(h_total), .h_displayed(h_displayed), .h_sync_pos(h_sync_pos),
        .h_sync_width(h_sync_width), .v_total(v_total), .v_line_adjust(v_line_adjust),
        .v_displayed(v_displayed), .v_sync_pos(v_sync_pos), .v_sync_width(v_sync_width),
        .char_height(char_height), .start_address(start_address)
    );

    crtc_h_timing u_h_timing (
        .pi_read(pi_read), .reset(reset), .h_total(h_total), .h_displayed(h_displayed),
        .h_sync_pos(h_sync_pos), .h_sync_width(h_sync_width), .h_count(h_count),
        .h_display(h_display), .hsync_raw(hsync_raw), .line_end(line_end)
    );

    // Vertical timing steps once per line, on the horizontal wrap.
    crtc_v_timing u_v_timing (
        .pi_read(pi_read), .reset(reset), .line_end(line_end), .char_height(char_height),
        .v_total(v_total), .v_line_adjust(v_line_adjust), .v_displayed(v_displayed),
        .v_sync_pos(v_sync_pos), .v_sync_width(v_sync_width), .h_displayed(h_displayed),
        .start_address(start_address), .scan_line(scan_line), .v_display(v_display),
        .vsync_raw(vsync_raw), .row_start(row_start)
    );

    crtc_video_combine u_video_combine (
        .pi_read(pi_read), .reset(reset), .h_count(h_count), .h_display(h_display),
        .hsync_raw(hsync_raw), .v_display(v_display), .vsync_raw(vsync_raw),
        .scan_line(scan_line), .row_start(row_start), .hsync(hsync), .vsync(vsync),
        .display_enable(display_enable), .memory_address(memory_address),
        .row_address(row_address)
    );
endmodule

`default_nettype wire

/* logic/crtc_v_timing.sv */
// Advances only on line_end; vsync arms at the end of scan line 0 of row v_sync_pos.
`default_nettype none

module crtc_v_timing import crtc_pkg::*; (
    input  wire                        pi_read,
    input  wire                        reset,
    input  wire                        line_end,
    input  wire [scan_bits-1:0]        char_height,
    input  wire [v_bits-1:0]           v_total,
    input  wire [adjust_bits-1:0]      v_line_adjust,
    input  wire [v_bits-1:0]           v_displayed,
    input  wire [v_bits-1:0]           v_sync_pos,
    input  wire [sync_width_bits-1:0] v_sync_width,
    input  wire [h_bits-1:0]           h_displayed,
    input  wire [addr_bits-1:0]        start_address,
    output logic [scan_bits-1:0]       scan_line,
    output logic                       v_display,
    output logic                       vsync_raw,
    output logic [addr_bits-1:0]       row_start
);
    logic [v_bits-1:0]        row;            // Text row within the frame.
    logic [adjust_bits-1:0]   adjust_count;   // Extra scan lines done so far.
    logic                     in_adjust;      // High during the lines after the last row.
    logic [sync_width_bits:0] vsync_left;     // Scan lines of vsync still to run.
    logic                     last_scan;
    logic                     last_row;
    logic                     adjust_last;
    logic                     frame_end;
    logic                     vsync_start;

    // The compares use greater-or-equal so a shrunken register still wraps.
    assign last_scan   = scan_line >= char_height;
    assign last_row    = row >= v_total;
    assign adjust_last = ({1'b0, adjust_count} + 1'b1) >= {1'b0, v_line_adjust};

    // With no adjust lines, the frame ends on the last scan line of the last row.
    assign frame_end = line_end &&
                       (in_adjust ? adjust_last : (last_scan && last_row && v_line_adjust == '0));

    always_ff @(posedge pi_read) begin
        if (reset) begin
            scan_line    <= '0;
            row          <= '0;
            adjust_count <= '0;
            in_adjust    <= 1'b0;
        end else if (frame_end) begin
            scan_line    <= '0;               // Start the next frame.
            row          <= '0;
            adjust_count <= '0;
            in_adjust    <= 1'b0;
        end else if (line_end) begin
            if (in_adjust) begin
                adjust_count <= adjust_count + 1'b1;
            end else if (!last_scan) begin
                scan_line <= scan_line + 1'b1;
            end else begin
                scan_line <= '0;
                if (last_row) begin
                    in_adjust <= 1'b1;        // Row stays put while the adjust lines run.
                end else begin
                    row <= row + 1'b1;
                end
            end
        end
    end

    assign v_display = (row < v_displayed) && !in_adjust;

    // Adjust lines never start vsync, and a running pulse is not restarted.
    assign vsync_start = line_end && !in_adjust && row == v_sync_pos &&
                         scan_line == '0 && vsync_left == '0;

    always_ff @(posedge pi_read) begin
        if (reset) begin
            vsync_left <= '0;
        end else if (vsync_start) begin
            vsync_left <= {v_sync_width == '0, v_sync_width};  // Zero reads as 16.
        end else if (line_end && vsync_left != '0) begin
            vsync_left <= vsync_left - 1'b1;
        end
    end

    assign vsync_raw = vsync_left != '0;

    // Each displayed row moves the address on by one line of characters.
    always_ff @(posedge pi_read) begin
        if (reset) begin
            row_start <= '0;
        end else if (frame_end) begin
            row_start <= start_address;       // R12 and R13 take effect once per frame.
        end else if (line_end && !in_adjust && last_scan && row < v_displayed) begin
            row_start <= row_start + addr_bits'(h_displayed);
        end
    end
endmodule

`default_nettype wire

/* logic/crtc_video_combine.sv */
// Every output lags the counter state that produced it by exactly one pi_read cycle.
`default_nettype none

module crtc_video_combine import crtc_pkg::*; (
    input  wire                  pi_read,
    input  wire                  reset,
    input  wire [h_bits-1:0]     h_count,
    input  wire                  h_display,
    input  wire                  hsync_raw,
    input  wire                  v_display,
    input  wire                  vsync_raw,
    input  wire [scan_bits-1:0]  scan_line,
    input  wire [addr_bits-1:0]  row_start,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 display_enable,
    output logic [addr_bits-1:0] memory_address,
    output logic [scan_bits-1:0] row_address
);
    logic [addr_bits-1:0] next_address;

    // The sum wraps at 16K, as the video bus does.
    assign next_address = row_start + addr_bits'(h_count);

    always_ff @(posedge pi_read) begin
        if (reset) begin
            hsync          <= 1'b0;
            vsync          <= 1'b0;
            display_enable <= 1'b0;
            memory_address <= '0;
            row_address    <= '0;
        end else begin
            hsync          <= hsync_raw;
            vsync          <= vsync_raw;
            display_enable <= h_display && v_display;  // Visible only inside both windows.
            memory_address <= next_address;
            row_address    <= scan_line;               // Picks the glyph line in the ROM.
        end
    end
endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the CRTC testbench with Verilator and runs it; the exit status is the verdict.
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module crtc_tb -f sim.f -o crtc_sim &&
./obj_dir/crtc_sim ||
{ echo "CRTC simulation build or run failed"; exit 1; }

/* sim.f */
logic/crtc_pkg.sv
logic/crtc_registers.sv
logic/crtc_h_timing.sv
logic/crtc_v_timing.sv
logic/crtc_video_combine.sv
logic/crtc_top.sv
verification/crtc_tb.sv

/* verification/crtc_tb.sv */
// Testbench for crtc_top; the raster model starts at reset and is only exact while registers stay below their field widths.
`default_nettype none

module crtc_tb import crtc_pkg::*; ();
    localparam int clock_period  = 8;
    localparam int watchdog_pad  = 100;              // Spare cycles on top of the table total.
    localparam logic [31:0] seed = 32'h1faa_5065;

    // Kinds of table entries.
    localparam logic [1:0] k_readback = 2'd0;        // Read the whole host window.
    localparam logic [1:0] k_program  = 2'd1;        // Write a fixed byte and read it back.
    localparam logic [1:0] k_raster   = 2'd2;        // Compare the video outputs with the model.
    localparam logic [1:0] k_random   = 2'd3;        // Write an LFSR byte, then a deselected write.

    typedef struct packed {
        logic [1:0]  kind;
        logic [4:0]  index;
        logic [7:0]  value;
        logic [15:0] cycles;                         // Cycle budget, also feeds the watchdog.
    } step_t;

    localparam int n_steps = 33;
    localparam step_t steps [n_steps] = '{
        '{k_readback, 5'd0, 8'h00, 16'd40},          // Power-up values.
        '{k_program, 5'd0, 8'd9, 16'd8},             // Ten characters per line.
        '{k_program, 5'd1, 8'd6, 16'd8},
        '{k_program, 5'd2, 8'd7, 16'd8},
        '{k_program, 5'd3, 8'h23, 16'd8},            // Vsync 2 lines, hsync 3 characters.
        '{k_program, 5'd4, 8'd3, 16'd8},
        '{k_program, 5'd5, 8'd2, 16'd8},             // Two adjust lines.
        '{k_program, 5'd6, 8'd3, 16'd8},
        '{k_program, 5'd7, 8'd2, 16'd8},
        '{k_program, 5'd9, 8'd2, 16'd8},             // Three scan lines per row.
        '{k_program, 5'd12, 8'hd3, 16'd8},           // Bits 7:6 must not reach the address.
        '{k_program, 5'd13, 8'h40, 16'd8},
        '{k_raster, 5'd0, 8'h00, 16'd340},
        '{k_program, 5'd3, 8'h50, 16'd8},            // Hsync width 0, which is 16.
        '{k_program, 5'd0, 8'd19, 16'd8},
        '{k_program, 5'd2, 8'd3, 16'd8},             // Sync covers characters 3 to 18.
        '{k_program, 5'd5, 8'd0, 16'd8},
        '{k_program, 5'd12, 8'h3f, 16'd8},           // Start near the top of the 16K space.
        '{k_program, 5'd13, 8'hf8, 16'd8},
        '{k_raster, 5'd0, 8'h00, 16'd600},
        '{k_program, 5'd3, 8'h04, 16'd8},            // Vsync width 0, which is 16 lines.
        '{k_program, 5'd4, 8'd5, 16'd8},
        '{k_program, 5'd7, 8'd1, 16'd8},
        '{k_raster, 5'd0, 8'h00, 16'd700},
        '{k_readback, 5'd0, 8'h00, 16'd40},
        '{k_random, 5'd0, 8'h00, 16'd14},
        '{k_random, 5'd3, 8'h00, 16'd14},
        '{k_random, 5'd7, 8'h00, 16'd14},
        '{k_random, 5'd12, 8'h00, 16'd14},
        '{k_random, 5'd15, 8'h00, 16'd14},
        '{k_random, 5'd17, 8'h00, 16'd14},           // Not visible to the host.
        '{k_program, 5'd18, 8'haa, 16'd8},           // No such register.
        '{k_readback, 5'd0, 8'h00, 16'd40}
    };

    logic                 pi_read = 1'b0;
    logic                 reset;
    logic                 crtc_select;
    logic [16:0]          bus_addr;
    logic [7:0]           bus_data_in;
    logic                 cpu_write;
    logic [15:0]          pi_addr;
    logic [7:0]           crtc_data_out;
    logic                 crtc_data_out_enable;
    logic                 hsync;
    logic                 vsync;
    logic                 display_enable;
    logic [addr_bits-1:0] memory_address;
    logic [scan_bits-1:0] row_address;

    logic [31:0] lfsr;
    int          hsync_rises;
    int          vsync_rises;
    int          visible_cycles;

    // Model state; the expected outputs carry the one-cycle combiner delay.
    logic [7:0]           m_regs [reg_count];
    int                   m_index;
    int                   m_h;
    int                   m_scan;
    int                   m_row;
    int                   m_adj;
    logic                 m_in_adj;
    int                   m_vs_left;
    int                   m_row_start;
    logic                 exp_hsync;
    logic                 exp_vsync;
    logic                 exp_de;
    logic [addr_bits-1:0] exp_addr;
    logic [scan_bits-1:0] exp_row;

    crtc_top dut (
        .pi_read(pi_read), .reset(reset), .crtc_select(crtc_select), .bus_addr(bus_addr),
        .bus_data_in(bus_data_in), .cpu_write(cpu_write), .pi_addr(pi_addr),
        .crtc_data_out(crtc_data_out), .crtc_data_out_enable(crtc_data_out_enable),
        .hsync(hsync), .vsync(vsync), .display_enable(display_enable),
        .memory_address(memory_address), .row_address(row_address)
    );

    always #(clock_period / 2) pi_read = ~pi_read;

    // Reference raster, stepped on the same edge as the DUT.
    always @(posedge pi_read) begin : raster_model
        int   ht, hd, hsp, hw, vt, adj, vd, vsp, vw, ch, st;
        logic frame_done;
        logic vs_start;
        logic row_done;
        ht  = int'(m_regs[r0_h_total]);
        hd  = int'(m_regs[r1_h_displayed]);
        hsp = int'(m_regs[r2_h_sync_pos]);
        hw  = int'(m_regs[r3_sync_width][3:0]);
        vw  = int'(m_regs[r3_sync_width][7:4]);
        vt  = int'(m_regs[r4_v_total][v_bits-1:0]);
        adj = int'(m_regs[r5_v_line_adjust][adjust_bits-1:0]);
        vd  = int'(m_regs[r6_v_displayed][v_bits-1:0]);
        vsp = int'(m_regs[r7_v_sync_pos][v_bits-1:0]);
        ch  = int'(m_regs[r9_scan_line][scan_bits-1:0]);
        st  = int'({m_regs[r12_start_high][5:0], m_regs[r13_start_low]});
        if (hw == 0) hw = 16;                        // Zero width means 16.
        if (vw == 0) vw = 16;
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                m_regs[i] = reset_values[i];
            end
            m_index = 0;
            m_h = 0;
            m_scan = 0;
            m_row = 0;
            m_adj = 0;
            m_in_adj = 1'b0;
            m_vs_left = 0;
            m_row_start = 0;
            exp_hsync = 1'b0;
            exp_vsync = 1'b0;
            exp_de = 1'b0;
            exp_addr = '0;
            exp_row = '0;
        end else begin
            exp_hsync = (((m_h - hsp) % 256 + 256) % 256) < hw;
            exp_vsync = m_vs_left > 0;
            exp_de    = (m_h < hd) && (m_row < vd) && !m_in_adj;
            exp_addr  = addr_bits'((m_row_start + m_h) % 16384);
            exp_row   = scan_bits'(m_scan);
            if (m_h >= ht) begin                     // End of the line.
                frame_done = m_in_adj ? (m_adj + 1 >= adj)
                                      : (m_scan >= ch && m_row >= vt && adj == 0);
                vs_start = !m_in_adj && m_row == vsp && m_scan == 0 && m_vs_left == 0;
                row_done = !m_in_adj && m_scan >= ch && m_row < vd;
                if (vs_start) m_vs_left = vw;
                else if (m_vs_left > 0) m_vs_left--;
                if (frame_done) m_row_start = st;
                else if (row_done) m_row_start = (m_row_start + hd) % 16384;
                if (frame_done) begin
                    m_scan = 0;
                    m_row = 0;
                    m_adj = 0;
                    m_in_adj = 1'b0;
                end else if (m_in_adj) begin
                    m_adj++;
                end else if (m_scan < ch) begin
                    m_scan++;
                end else begin
                    m_scan = 0;
                    if (m_row >= vt) m_in_adj = 1'b1;  // Row holds during the adjust lines.
                    else m_row++;
                end
                m_h = 0;
            end else begin
                m_h++;
            end
            // The register file sees the bus after the counters used the old values.
            if (crtc_select && cpu_write) begin
                if (!bus_addr[0]) m_index = int'(bus_data_in[4:0]);
                else if (m_index < reg_count) m_regs[m_index] = bus_data_in;
            end
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // Galois form, shifting right.
    endfunction

    task automatic take_random_byte(output logic [7:0] b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_step(lfsr);                  // One step for every bit used.
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got,
                              input logic [7:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_address(input string what, input logic [addr_bits-1:0] got,
                                 input logic [addr_bits-1:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_row(input string what, input logic [scan_bits-1:0] got,
                             input logic [scan_bits-1:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // Even then odd access; with select low neither half may land.
    task automatic bus_write(input logic [4:0] idx, input logic [7:0] value, input logic select);
        @(posedge pi_read);
        crtc_select <= select;
        cpu_write   <= 1'b1;
        bus_addr    <= 17'hE8F0;
        bus_data_in <= {3'b000, idx};
        @(posedge pi_read);
        bus_addr    <= 17'hE8F1;
        bus_data_in <= value;
        @(posedge pi_read);
        crtc_select <= 1'b0;
        cpu_write   <= 1'b0;
    endtask

    task automatic read_one(input int idx, input logic [7:0] expected);
        @(posedge pi_read);
        pi_addr <= host_window_low + 16'(idx);
        @(negedge pi_read);
        check_bit("read enable", crtc_data_out_enable, 1'b1);  // Enable is immediate.
        @(negedge pi_read);
        check_byte("read-back byte", crtc_data_out, expected);  // Byte comes a cycle later.
    endtask

    task automatic read_window();
        logic [7:0]  held;
        logic [15:0] outside [2];
        outside[0] = host_window_low - 16'd1;
        outside[1] = host_window_high + 16'd1;
        for (int a = 0; a < 16; a++) begin
            read_one(a, m_regs[a]);
        end
        for (int j = 0; j < 2; j++) begin
            held = crtc_data_out;
            @(posedge pi_read);
            pi_addr <= outside[j];
            @(negedge pi_read);
            check_bit("enable outside window", crtc_data_out_enable, 1'b0);
            @(negedge pi_read);
            check_byte("held read-back byte", crtc_data_out, held);
        end
    endtask

    task automatic check_raster(input int cycles);
        logic prev_h;
        logic prev_v;
        prev_h = hsync;
        prev_v = vsync;
        repeat (cycles) begin
            @(negedge pi_read);                      // Outputs are settled mid-cycle.
            check_bit("hsync", hsync, exp_hsync);
            check_bit("vsync", vsync, exp_vsync);
            check_bit("display_enable", display_enable, exp_de);
            check_address("memory_address", memory_address, exp_addr);
            check_row("row_address", row_address, exp_row);
            if (hsync && !prev_h) hsync_rises++;
            if (vsync && !prev_v) vsync_rises++;
            if (display_enable) visible_cycles++;
            prev_h = hsync;
            prev_v = vsync;
        end
    endtask

    initial begin : stimulus
        logic [7:0] b;
        int         idx;
        reset = 1'b1;
        crtc_select = 1'b0;
        bus_addr = '0;
        bus_data_in = '0;
        cpu_write = 1'b0;
        pi_addr = '0;
        lfsr = seed;
        hsync_rises = 0;
        vsync_rises = 0;
        visible_cycles = 0;
        repeat (2) @(posedge pi_read);
        reset <= 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            idx = int'(steps[i].index);
            case (steps[i].kind)
                k_readback: read_window();
                k_program: begin
                    bus_write(steps[i].index, steps[i].value, 1'b1);
                    if (idx < 16) read_one(idx, steps[i].value);
                end
                k_raster: check_raster(int'(steps[i].cycles));
                default: begin
                    take_random_byte(b);
                    bus_write(steps[i].index, b, 1'b1);
                    if (idx < 16) read_one(idx, b);
                    bus_write(steps[i].index, ~b, 1'b0);  // Deselected, so ignored.
                    if (idx < 16) read_one(idx, b);
                end
            endcase
        end
        if (hsync_rises == 0 || vsync_rises == 0 || visible_cycles == 0) begin
            $display("Simulation FAILED");
            $fatal(1, "The raster checks never saw hsync, vsync or a visible cycle");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin : watchdog
        int total;
        total = watchdog_pad;
        for (int i = 0; i < n_steps; i++) begin
            total += int'(steps[i].cycles);
        end
        #(total * clock_period);
        $display("Simulation FAILED");
        $fatal(1, "Timeout: the test table did not finish in the expected time");
    end
endmodule

`default_nettype wire
